/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = lsq_tb
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TEST OK$$" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+include
hw/lsq_pkg.sv
hw/lsq_if.sv
hw/store_queue.sv
hw/load_queue.sv
hw/lsq_top.sv
tests/lsq_tb.sv

/* hw/load_queue.sv */
`timescale 1ns/10ps
`include "lsq_config.svh"

module load_queue import lsq_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [`LSQ_WAYS-1:0] dispatch_load,
  input  logic                 dispatch_accept,
  input  logic                 load_exec,
  input  idx_t                 load_exec_idx,
  input  addr_t                load_exec_addr,
  input  logic [`LSQ_WAYS-1:0] retire_load,
  input  logic                 rollback,
  input  ptr_t                 lq_rollback_ptr,
  output idx_t [`LSQ_WAYS-1:0] lq_alloc_idx,
  output ptr_t                 lq_free,
  output logic                 load_done,
  output logic                 load_fwd_hit,
  output data_t                load_fwd_data,
  output idx_t                 load_done_idx,
  output logic                 violation,
  output idx_t                 violation_lq_idx,
  lsq_if.lq_side               lsq
);

  lq_entry_t            lq [`LSQ_DEPTH];
  ptr_t                 head, tail, used;
  ptr_t                 alloc_count, retire_count, squash_span;
  idx_t                 head_idx;
  idx_t [`LSQ_WAYS-1:0] retire_idx;
  logic                 viol_found;
  idx_t                 viol_idx;

  assign head_idx     = head[`LSQ_IDX_W-1:0];
  assign used         = tail - head;
  assign lq_free      = ptr_t'(`LSQ_DEPTH) - used;
  assign alloc_count  = ptr_t'(dispatch_load[0]) + ptr_t'(dispatch_load[1]);
  assign retire_count = ptr_t'(retire_load[0]) + ptr_t'(retire_load[1]);
  assign squash_span  = tail - lq_rollback_ptr;

  assign lq_alloc_idx[0] = tail[`LSQ_IDX_W-1:0];
  assign lq_alloc_idx[1] = tail[`LSQ_IDX_W-1:0] + idx_t'(dispatch_load[0]);
  assign retire_idx[0]   = head_idx;
  assign retire_idx[1]   = head_idx + idx_t'(retire_load[0]);

  assign lsq.load_lookup     = load_exec;
  assign lsq.load_tag        = tag_of(load_exec_addr);
  assign lsq.load_store_tail = lq[load_exec_idx].store_tail;

  // Oldest executed load that the store is older than.
  // The store is older when it sits 1 to DEPTH slots below the load's store_tail.
  always_comb begin
    idx_t idx;
    ptr_t gap;
    viol_found = 1'b0;
    viol_idx   = '0;
    for (int j = 0; j < `LSQ_DEPTH; j++) begin
      idx = head_idx + idx_t'(j);
      gap = lq[idx].store_tail - lsq.store_ptr;
      if (!viol_found && ptr_t'(j) < used && lq[idx].state == EXECUTED &&
          lq[idx].tag == lsq.store_tag && gap != '0 && gap <= ptr_t'(`LSQ_DEPTH)) begin
        viol_found = 1'b1;
        viol_idx   = idx;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
        lq[i].state <= EMPTY;
      end
    end else begin
      head <= head + retire_count;
      if (rollback) begin
        tail <= lq_rollback_ptr;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
          if (ptr_t'(idx_t'(i) - lq_rollback_ptr[`LSQ_IDX_W-1:0]) < squash_span) begin
            lq[i].state <= EMPTY;
          end
        end
      end else if (dispatch_accept) begin
        tail <= tail + alloc_count;
        for (int w = 0; w < `LSQ_WAYS; w++) begin
          if (dispatch_load[w]) begin
            lq[lq_alloc_idx[w]].state      <= ALLOCATED;
            lq[lq_alloc_idx[w]].store_tail <= lsq.dispatch_store_tail[w];
          end
        end
      end
      if (load_exec) begin
        lq[load_exec_idx].state <= EXECUTED;
        lq[load_exec_idx].tag   <= tag_of(load_exec_addr);
      end
      // Retired loads only give back their slot
      for (int w = 0; w < `LSQ_WAYS; w++) begin
        if (retire_load[w]) begin
          lq[retire_idx[w]].state <= EMPTY;
        end
      end
    end
  end

  // Load response and violation report
  always_ff @(posedge clock) begin
    if (reset) begin
      load_done    <= 1'b0;
      load_fwd_hit <= 1'b0;
      violation    <= 1'b0;
    end else begin
      load_done    <= load_exec;
      load_fwd_hit <= lsq.fwd_hit;
      violation    <= lsq.store_check && viol_found;
    end
  end

  always_ff @(posedge clock) begin
    load_fwd_data    <= lsq.fwd_data;
    load_done_idx    <= load_exec_idx;
    violation_lq_idx <= viol_idx;
  end

  a_lq_retire_in_range: assert property (@(posedge clock) disable iff (reset)
    retire_count <= used);

endmodule

/* hw/lsq_if.sv */
`timescale 1ns/10ps
`include "lsq_config.svh"

interface lsq_if import lsq_pkg::*; ();

  // Load lookup, answered in the same cycle
  logic  load_lookup;
  tag_t  load_tag;
  ptr_t  load_store_tail;
  logic  fwd_hit;
  data_t fwd_data;

  // Executing store, checked against younger loads
  logic store_check;
  tag_t store_tag;
  ptr_t store_ptr;

  // SQ tail as seen by a load in each dispatch way
  ptr_t [`LSQ_WAYS-1:0] dispatch_store_tail;

  modport sq_side (
    input  load_lookup, load_tag, load_store_tail,
    output fwd_hit, fwd_data,
    output store_check, store_tag, store_ptr,
    output dispatch_store_tail
  );

  modport lq_side (
    output load_lookup, load_tag, load_store_tail,
    input  fwd_hit, fwd_data,
    input  store_check, store_tag, store_ptr,
    input  dispatch_store_tail
  );

endinterface

/* hw/lsq_pkg.sv */
`include "lsq_config.svh"

package lsq_pkg;

  typedef logic [`LSQ_PTR_W-1:0]  ptr_t;
  typedef logic [`LSQ_IDX_W-1:0]  idx_t;
  typedef logic [`LSQ_ADDR_W-1:0] addr_t;
  typedef logic [`LSQ_TAG_W-1:0]  tag_t;
  typedef logic [`LSQ_DATA_W-1:0] data_t;

  // ALLOCATED means dispatched but address still unknown
  typedef enum logic [1:0] {
    EMPTY,
    ALLOCATED,
    EXECUTED
  } entry_state_e;

  typedef struct packed {
    entry_state_e state;
    tag_t         tag;
    data_t        data;
  } sq_entry_t;

  // store_tail marks every store older than the load
  typedef struct packed {
    entry_state_e state;
    tag_t         tag;
    ptr_t         store_tail;
  } lq_entry_t;

  function automatic tag_t tag_of(addr_t addr);
    return addr[`LSQ_ADDR_W-1:`LSQ_OFFSET_W];
  endfunction

endpackage

/* hw/lsq_top.sv */
`timescale 1ns/10ps
`include "lsq_config.svh"

module lsq_top import lsq_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  // Dispatch
  input  logic [`LSQ_WAYS-1:0]  dispatch_store,
  input  logic [`LSQ_WAYS-1:0]  dispatch_load,
  output logic                  dispatch_ready,
  output idx_t [`LSQ_WAYS-1:0]  sq_alloc_idx,
  output idx_t [`LSQ_WAYS-1:0]  lq_alloc_idx,
  // Store execute
  input  logic                  store_exec,
  input  idx_t                  store_exec_idx,
  input  addr_t                 store_exec_addr,
  input  data_t                 store_exec_data,
  // Load execute
  input  logic                  load_exec,
  input  idx_t                  load_exec_idx,
  input  addr_t                 load_exec_addr,
  output logic                  load_done,
  output logic                  load_fwd_hit,
  output data_t                 load_fwd_data,
  output idx_t                  load_done_idx,
  output logic                  violation,
  output idx_t                  violation_lq_idx,
  // Retire and memory write
  input  logic [`LSQ_WAYS-1:0]  retire_store,
  input  logic [`LSQ_WAYS-1:0]  retire_load,
  output logic [`LSQ_WAYS-1:0]  mem_wr_en,
  output addr_t [`LSQ_WAYS-1:0] mem_wr_addr,
  output data_t [`LSQ_WAYS-1:0] mem_wr_data,
  // Rollback
  input  logic                  rollback,
  input  ptr_t                  sq_rollback_ptr,
  input  ptr_t                  lq_rollback_ptr
);

  ptr_t sq_free, lq_free;
  ptr_t store_count, load_count;

  lsq_if lsq ();

  // Whole group or nothing
  assign store_count    = ptr_t'(dispatch_store[0]) + ptr_t'(dispatch_store[1]);
  assign load_count     = ptr_t'(dispatch_load[0]) + ptr_t'(dispatch_load[1]);
  assign dispatch_ready = (sq_free >= store_count) && (lq_free >= load_count);

  store_queue i_store_queue (
    .clock           (clock),
    .reset           (reset),
    .dispatch_store  (dispatch_store),
    .dispatch_accept (dispatch_ready),
    .store_exec      (store_exec),
    .store_exec_idx  (store_exec_idx),
    .store_exec_addr (store_exec_addr),
    .store_exec_data (store_exec_data),
    .retire_store    (retire_store),
    .rollback        (rollback),
    .sq_rollback_ptr (sq_rollback_ptr),
    .sq_alloc_idx    (sq_alloc_idx),
    .sq_free         (sq_free),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_addr     (mem_wr_addr),
    .mem_wr_data     (mem_wr_data),
    .lsq             (lsq.sq_side)
  );

  load_queue i_load_queue (
    .clock            (clock),
    .reset            (reset),
    .dispatch_load    (dispatch_load),
    .dispatch_accept  (dispatch_ready),
    .load_exec        (load_exec),
    .load_exec_idx    (load_exec_idx),
    .load_exec_addr   (load_exec_addr),
    .retire_load      (retire_load),
    .rollback         (rollback),
    .lq_rollback_ptr  (lq_rollback_ptr),
    .lq_alloc_idx     (lq_alloc_idx),
    .lq_free          (lq_free),
    .load_done        (load_done),
    .load_fwd_hit     (load_fwd_hit),
    .load_fwd_data    (load_fwd_data),
    .load_done_idx    (load_done_idx),
    .violation        (violation),
    .violation_lq_idx (violation_lq_idx),
    .lsq              (lsq.lq_side)
  );

endmodule

/* hw/store_queue.sv */
`timescale 1ns/10ps
`include "lsq_config.svh"

module store_queue import lsq_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [`LSQ_WAYS-1:0]  dispatch_store,
  input  logic                  dispatch_accept,
  input  logic                  store_exec,
  input  idx_t                  store_exec_idx,
  input  addr_t                 store_exec_addr,
  input  data_t                 store_exec_data,
  input  logic [`LSQ_WAYS-1:0]  retire_store,
  input  logic                  rollback,
  input  ptr_t                  sq_rollback_ptr,
  output idx_t [`LSQ_WAYS-1:0]  sq_alloc_idx,
  output ptr_t                  sq_free,
  output logic [`LSQ_WAYS-1:0]  mem_wr_en,
  output addr_t [`LSQ_WAYS-1:0] mem_wr_addr,
  output data_t [`LSQ_WAYS-1:0] mem_wr_data,
  lsq_if.sq_side                lsq
);

  sq_entry_t            sq [`LSQ_DEPTH];
  ptr_t                 head, tail, used;
  ptr_t                 alloc_count, retire_count, squash_span, fwd_span;
  idx_t                 head_idx, exec_offset;
  idx_t [`LSQ_WAYS-1:0] retire_idx;
  logic                 fwd_found;
  data_t                fwd_value;

  assign head_idx     = head[`LSQ_IDX_W-1:0];
  assign used         = tail - head;
  assign sq_free      = ptr_t'(`LSQ_DEPTH) - used;
  assign alloc_count  = ptr_t'(dispatch_store[0]) + ptr_t'(dispatch_store[1]);
  assign retire_count = ptr_t'(retire_store[0]) + ptr_t'(retire_store[1]);
  assign squash_span  = tail - sq_rollback_ptr;

  // Compact in way order, way 0 is older
  assign sq_alloc_idx[0] = tail[`LSQ_IDX_W-1:0];
  assign sq_alloc_idx[1] = tail[`LSQ_IDX_W-1:0] + idx_t'(dispatch_store[0]);
  assign retire_idx[0]   = head_idx;
  assign retire_idx[1]   = head_idx + idx_t'(retire_store[0]);

  assign lsq.dispatch_store_tail[0] = tail;
  assign lsq.dispatch_store_tail[1] = tail + ptr_t'(dispatch_store[0]);

  // Rebuild the wrap bit of the executing store from its distance to head
  assign exec_offset     = store_exec_idx - head_idx;
  assign lsq.store_check = store_exec;
  assign lsq.store_tag   = tag_of(store_exec_addr);
  assign lsq.store_ptr   = head + ptr_t'(exec_offset);

  // Youngest older store first
  assign fwd_span = lsq.load_store_tail - head;

  always_comb begin
    idx_t idx;
    fwd_found = 1'b0;
    fwd_value = '0;
    for (int j = 0; j < `LSQ_DEPTH; j++) begin
      idx = lsq.load_store_tail[`LSQ_IDX_W-1:0] - idx_t'(j + 1);
      if (!fwd_found && ptr_t'(j) < fwd_span && sq[idx].state == EXECUTED &&
          sq[idx].tag == lsq.load_tag) begin
        fwd_found = 1'b1;
        fwd_value = sq[idx].data;
      end
    end
  end

  assign lsq.fwd_hit  = lsq.load_lookup && fwd_found;
  assign lsq.fwd_data = fwd_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < `LSQ_DEPTH; i++) begin
        sq[i].state <= EMPTY;
      end
    end else begin
      head <= head + retire_count;
      if (rollback) begin
        tail <= sq_rollback_ptr;
        for (int i = 0; i < `LSQ_DEPTH; i++) begin
          if (ptr_t'(idx_t'(i) - sq_rollback_ptr[`LSQ_IDX_W-1:0]) < squash_span) begin
            sq[i].state <= EMPTY;
          end
        end
      end else if (dispatch_accept) begin
        tail <= tail + alloc_count;
        for (int w = 0; w < `LSQ_WAYS; w++) begin
          if (dispatch_store[w]) begin
            sq[sq_alloc_idx[w]].state <= ALLOCATED;
          end
        end
      end
      if (store_exec) begin
        sq[store_exec_idx].state <= EXECUTED;
        sq[store_exec_idx].tag   <= tag_of(store_exec_addr);
        sq[store_exec_idx].data  <= store_exec_data;
      end
      for (int w = 0; w < `LSQ_WAYS; w++) begin
        if (retire_store[w]) begin
          sq[retire_idx[w]].state <= EMPTY;
        end
      end
    end
  end

  // Memory write port, head first
  always_ff @(posedge clock) begin
    if (reset) begin
      mem_wr_en <= '0;
    end else begin
      mem_wr_en <= retire_store;
    end
  end

  always_ff @(posedge clock) begin
    for (int w = 0; w < `LSQ_WAYS; w++) begin
      mem_wr_addr[w] <= {sq[retire_idx[w]].tag, `LSQ_OFFSET_W'(0)};
      mem_wr_data[w] <= sq[retire_idx[w]].data;
    end
  end

  a_sq_retire_in_range: assert property (@(posedge clock) disable iff (reset)
    retire_count <= used);

  a_sq_exec_in_range: assert property (@(posedge clock) disable iff (reset)
    store_exec |-> ptr_t'(exec_offset) < used);

endmodule

/* include/lsq_config.svh */
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// Queue geometry
`define LSQ_DEPTH 8
`define LSQ_IDX_W 3
// One wrap bit above the index
`define LSQ_PTR_W 4

// Dispatch and retire width
`define LSQ_WAYS 2

// Address and data sizes
`define LSQ_ADDR_W 32
`define LSQ_DATA_W 64

// Doubleword offset, the rest of the address is the match tag
`define LSQ_OFFSET_W 3
`define LSQ_TAG_W (`LSQ_ADDR_W - `LSQ_OFFSET_W)

`endif

/* tests/lsq_tb.sv */
`timescale 1ns/10ps
`include "lsq_config.svh"

module lsq_tb import lsq_pkg::*; ();

  typedef enum logic [2:0] {
    OP_DISPATCH,
    OP_STORE_EXEC,
    OP_LOAD_EXEC,
    OP_RETIRE,
    OP_ROLLBACK,
    OP_IDLE
  } op_e;

  // st and ld hold dispatch masks or retire masks for OP_RETIRE
  typedef struct packed {
    op_e                  kind;
    logic [`LSQ_WAYS-1:0] st;
    logic [`LSQ_WAYS-1:0] ld;
    idx_t                 idx;
    addr_t                addr;
    ptr_t                 sq_ptr;
    ptr_t                 lq_ptr;
  } row_t;

  logic                  clock;
  logic                  reset;
  logic [`LSQ_WAYS-1:0]  dispatch_store;
  logic [`LSQ_WAYS-1:0]  dispatch_load;
  logic                  dispatch_ready;
  idx_t [`LSQ_WAYS-1:0]  sq_alloc_idx;
  idx_t [`LSQ_WAYS-1:0]  lq_alloc_idx;
  logic                  store_exec;
  idx_t                  store_exec_idx;
  addr_t                 store_exec_addr;
  data_t                 store_exec_data;
  logic                  load_exec;
  idx_t                  load_exec_idx;
  addr_t                 load_exec_addr;
  logic                  load_done;
  logic                  load_fwd_hit;
  data_t                 load_fwd_data;
  idx_t                  load_done_idx;
  logic                  violation;
  idx_t                  violation_lq_idx;
  logic [`LSQ_WAYS-1:0]  retire_store;
  logic [`LSQ_WAYS-1:0]  retire_load;
  logic [`LSQ_WAYS-1:0]  mem_wr_en;
  addr_t [`LSQ_WAYS-1:0] mem_wr_addr;
  data_t [`LSQ_WAYS-1:0] mem_wr_data;
  logic                  rollback;
  ptr_t                  sq_rollback_ptr;
  ptr_t                  lq_rollback_ptr;

  // Reference queues
  ptr_t         sq_head, sq_tail, lq_head, lq_tail;
  entry_state_e sq_state [`LSQ_DEPTH];
  addr_t        sq_addr [`LSQ_DEPTH];
  data_t        sq_data [`LSQ_DEPTH];
  ptr_t         sq_ptr_of [`LSQ_DEPTH];
  entry_state_e lq_state [`LSQ_DEPTH];
  addr_t        lq_addr [`LSQ_DEPTH];
  ptr_t         lq_stail [`LSQ_DEPTH];

  logic                  exp_done, exp_hit, exp_viol;
  data_t                 exp_fwd;
  idx_t                  exp_done_idx, exp_viol_idx;
  logic [`LSQ_WAYS-1:0]  exp_en;
  addr_t [`LSQ_WAYS-1:0] exp_addr;
  data_t [`LSQ_WAYS-1:0] exp_wdata;

  row_t        stim [$];
  data_t       cur_data;
  logic [31:0] lcg_state = 32'd85027;
  int          cycle_count;
  int          err_dispatch, err_load, err_viol, err_mem;

  lsq_top i_lsq_top (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic row_t make_row(op_e kind, logic [1:0] st, logic [1:0] ld, idx_t idx,
                                    addr_t addr, ptr_t sp, ptr_t lp);
    row_t r;
    r.kind   = kind;
    r.st     = st;
    r.ld     = ld;
    r.idx    = idx;
    r.addr   = addr;
    r.sq_ptr = sp;
    r.lq_ptr = lp;
    return r;
  endfunction

  function automatic ptr_t free_slots(ptr_t tail, ptr_t head);
    return ptr_t'(`LSQ_DEPTH) - (tail - head);
  endfunction

  // Number of stores still queued that are older than a load
  function automatic ptr_t older_span(ptr_t stail);
    ptr_t d;
    d = stail - sq_head;
    if (d > ptr_t'(`LSQ_DEPTH)) begin
      return '0;
    end
    return d;
  endfunction

  task automatic build_table();
    // Two stores, then mixed groups with one store younger than both loads
    stim.push_back(make_row(OP_DISPATCH, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b01, 2'b10, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b10, 2'b01, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd0, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd1, 32'h104, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd3, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_LOAD_EXEC, 2'b00, 2'b00, 3'd0, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_LOAD_EXEC, 2'b00, 2'b00, 3'd1, 32'h200, 4'd0, 4'd0));
    // Late store hits an executed younger load
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd2, 32'h103, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd3, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_LOAD_EXEC, 2'b00, 2'b00, 3'd1, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd1, 32'h100, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b01, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b01, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    // Fill the store queue across the wrap, then stall
    stim.push_back(make_row(OP_DISPATCH, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b01, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b01, 2'b10, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b01, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd6, 32'h300, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd7, 32'h308, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd0, 32'h310, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd4, 32'h300, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd5, 32'h318, 4'd0, 4'd0));
    stim.push_back(make_row(OP_LOAD_EXEC, 2'b00, 2'b00, 3'd2, 32'h300, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd1, 32'h320, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b01, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b11, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    // Rollback squashes sq3 and lq3 and drops the dispatch in the same cycle
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b01, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd2, 32'h400, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd3, 32'h400, 4'd0, 4'd0));
    stim.push_back(make_row(OP_ROLLBACK, 2'b01, 2'b00, 3'd0, 32'h0, 4'd11, 4'd3));
    stim.push_back(make_row(OP_DISPATCH, 2'b01, 2'b10, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_LOAD_EXEC, 2'b00, 2'b00, 3'd3, 32'h400, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd3, 32'h408, 4'd0, 4'd0));
    stim.push_back(make_row(OP_STORE_EXEC, 2'b00, 2'b00, 3'd3, 32'h400, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b11, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_RETIRE, 2'b01, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
    // Fill the load queue, then stall on it
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b00, 2'b11, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_DISPATCH, 2'b01, 2'b01, 3'd0, 32'h0, 4'd0, 4'd0));
    stim.push_back(make_row(OP_IDLE, 2'b00, 2'b00, 3'd0, 32'h0, 4'd0, 4'd0));
  endtask

  task automatic drive_idle();
    dispatch_store  <= '0;
    dispatch_load   <= '0;
    store_exec      <= 1'b0;
    store_exec_idx  <= '0;
    store_exec_addr <= '0;
    store_exec_data <= '0;
    load_exec       <= 1'b0;
    load_exec_idx   <= '0;
    load_exec_addr  <= '0;
    retire_store    <= '0;
    retire_load     <= '0;
    rollback        <= 1'b0;
    sq_rollback_ptr <= '0;
    lq_rollback_ptr <= '0;
  endtask

  task automatic drive_row(input row_t r);
    drive_idle();
    case (r.kind)
      OP_DISPATCH: begin
        dispatch_store <= r.st;
        dispatch_load  <= r.ld;
      end
      OP_STORE_EXEC: begin
        cur_data = {lcg_next(), lcg_next()};
        store_exec      <= 1'b1;
        store_exec_idx  <= r.idx;
        store_exec_addr <= r.addr;
        store_exec_data <= cur_data;
      end
      OP_LOAD_EXEC: begin
        load_exec      <= 1'b1;
        load_exec_idx  <= r.idx;
        load_exec_addr <= r.addr;
      end
      OP_RETIRE: begin
        retire_store <= r.st;
        retire_load  <= r.ld;
      end
      OP_ROLLBACK: begin
        rollback        <= 1'b1;
        sq_rollback_ptr <= r.sq_ptr;
        lq_rollback_ptr <= r.lq_ptr;
        dispatch_store  <= r.st;
        dispatch_load   <= r.ld;
      end
      default: begin
      end
    endcase
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, sig, exp_val, act_val);
  endtask

  task automatic check_dispatch(input logic exp_ready, input idx_t [`LSQ_WAYS-1:0] exp_sq,
                                input idx_t [`LSQ_WAYS-1:0] exp_lq);
    if (dispatch_ready !== exp_ready) begin
      report_mismatch("dispatch_ready", 64'(exp_ready), 64'(dispatch_ready));
      err_dispatch++;
    end
    for (int w = 0; w < `LSQ_WAYS; w++) begin
      if (sq_alloc_idx[w] !== exp_sq[w]) begin
        report_mismatch($sformatf("sq_alloc_idx[%0d]", w), 64'(exp_sq[w]),
                        64'(sq_alloc_idx[w]));
        err_dispatch++;
      end
      if (lq_alloc_idx[w] !== exp_lq[w]) begin
        report_mismatch($sformatf("lq_alloc_idx[%0d]", w), 64'(exp_lq[w]),
                        64'(lq_alloc_idx[w]));
        err_dispatch++;
      end
    end
  endtask

  task automatic check_load_resp(input logic exp_d, input logic exp_h, input data_t exp_data,
                                 input idx_t exp_idx);
    if (load_done !== exp_d) begin
      report_mismatch("load_done", 64'(exp_d), 64'(load_done));
      err_load++;
    end else if (exp_d) begin
      if (load_done_idx !== exp_idx) begin
        report_mismatch("load_done_idx", 64'(exp_idx), 64'(load_done_idx));
        err_load++;
      end
      if (load_fwd_hit !== exp_h) begin
        report_mismatch("load_fwd_hit", 64'(exp_h), 64'(load_fwd_hit));
        err_load++;
      end else if (exp_h && load_fwd_data !== exp_data) begin
        report_mismatch("load_fwd_data", exp_data, load_fwd_data);
        err_load++;
      end
    end
  endtask

  task automatic check_violation(input logic exp_v, input idx_t exp_idx);
    if (violation !== exp_v) begin
      report_mismatch("violation", 64'(exp_v), 64'(violation));
      err_viol++;
    end else if (exp_v && violation_lq_idx !== exp_idx) begin
      report_mismatch("violation_lq_idx", 64'(exp_idx), 64'(violation_lq_idx));
      err_viol++;
    end
  endtask

  task automatic check_mem_write(input logic [`LSQ_WAYS-1:0] exp_e,
                                 input addr_t [`LSQ_WAYS-1:0] exp_a,
                                 input data_t [`LSQ_WAYS-1:0] exp_d);
    if (mem_wr_en !== exp_e) begin
      report_mismatch("mem_wr_en", 64'(exp_e), 64'(mem_wr_en));
      err_mem++;
    end else begin
      for (int w = 0; w < `LSQ_WAYS; w++) begin
        if (exp_e[w] && mem_wr_addr[w] !== exp_a[w]) begin
          report_mismatch($sformatf("mem_wr_addr[%0d]", w), 64'(exp_a[w]),
                          64'(mem_wr_addr[w]));
          err_mem++;
        end
        if (exp_e[w] && mem_wr_data[w] !== exp_d[w]) begin
          report_mismatch($sformatf("mem_wr_data[%0d]", w), exp_d[w], mem_wr_data[w]);
          err_mem++;
        end
      end
    end
  endtask

  // Predicts this row's responses, then advances the reference queues by one edge
  task automatic update_model(input row_t r);
    logic [`LSQ_WAYS-1:0] st, ld;
    idx_t [`LSQ_WAYS-1:0] exp_sq, exp_lq;
    ptr_t                 n_st, n_ld, p, sp, span;
    idx_t                 e;
    logic                 ready;
    st = (r.kind == OP_DISPATCH || r.kind == OP_ROLLBACK) ? r.st : 2'b00;
    ld = (r.kind == OP_DISPATCH || r.kind == OP_ROLLBACK) ? r.ld : 2'b00;
    n_st = ptr_t'(st[0]) + ptr_t'(st[1]);
    n_ld = ptr_t'(ld[0]) + ptr_t'(ld[1]);
    ready = free_slots(sq_tail, sq_head) >= n_st && free_slots(lq_tail, lq_head) >= n_ld;
    exp_sq[0] = idx_t'(sq_tail);
    exp_sq[1] = idx_t'(sq_tail + ptr_t'(st[0]));
    exp_lq[0] = idx_t'(lq_tail);
    exp_lq[1] = idx_t'(lq_tail + ptr_t'(ld[0]));
    check_dispatch(ready, exp_sq, exp_lq);
    exp_done     = 1'b0;
    exp_hit      = 1'b0;
    exp_fwd      = '0;
    exp_done_idx = '0;
    exp_viol     = 1'b0;
    exp_viol_idx = '0;
    exp_en       = '0;
    exp_addr     = '0;
    exp_wdata    = '0;
    case (r.kind)
      OP_DISPATCH: begin
        if (ready) begin
          for (int w = 0; w < `LSQ_WAYS; w++) begin
            // Stores in older ways count as older than a load in this way
            if (st[w]) begin
              sq_state[exp_sq[w]]  = ALLOCATED;
              sq_ptr_of[exp_sq[w]] = sq_tail + ptr_t'(w == 1 && st[0]);
            end
            if (ld[w]) begin
              lq_state[exp_lq[w]] = ALLOCATED;
              lq_stail[exp_lq[w]] = sq_tail + ptr_t'(w == 1 && st[0]);
            end
          end
          sq_tail = sq_tail + n_st;
          lq_tail = lq_tail + n_ld;
        end
      end
      OP_STORE_EXEC: begin
        sp = sq_ptr_of[r.idx];
        for (int j = 0; j < `LSQ_DEPTH; j++) begin
          e = idx_t'(lq_head + ptr_t'(j));
          if (!exp_viol && ptr_t'(j) < (lq_tail - lq_head) && lq_state[e] == EXECUTED &&
              (lq_addr[e] >> 3) == (r.addr >> 3) && (sp - sq_head) < older_span(lq_stail[e]))
          begin
            exp_viol     = 1'b1;
            exp_viol_idx = e;
          end
        end
        sq_state[r.idx] = EXECUTED;
        sq_addr[r.idx]  = r.addr;
        sq_data[r.idx]  = cur_data;
      end
      OP_LOAD_EXEC: begin
        span = older_span(lq_stail[r.idx]);
        for (int j = 1; j <= `LSQ_DEPTH; j++) begin
          e = idx_t'(lq_stail[r.idx] - ptr_t'(j));
          if (!exp_hit && ptr_t'(j) <= span && sq_state[e] == EXECUTED &&
              (sq_addr[e] >> 3) == (r.addr >> 3)) begin
            exp_hit = 1'b1;
            exp_fwd = sq_data[e];
          end
        end
        exp_done        = 1'b1;
        exp_done_idx    = r.idx;
        lq_state[r.idx] = EXECUTED;
        lq_addr[r.idx]  = r.addr;
      end
      OP_RETIRE: begin
        exp_en = r.st;
        for (int w = 0; w < `LSQ_WAYS; w++) begin
          if (r.st[w]) begin
            e = idx_t'(sq_head + ptr_t'(w));
            exp_addr[w]  = sq_addr[e] & ~addr_t'(7);
            exp_wdata[w] = sq_data[e];
            sq_state[e]  = EMPTY;
          end
          if (r.ld[w]) begin
            lq_state[idx_t'(lq_head + ptr_t'(w))] = EMPTY;
          end
        end
        sq_head = sq_head + ptr_t'(r.st[0]) + ptr_t'(r.st[1]);
        lq_head = lq_head + ptr_t'(r.ld[0]) + ptr_t'(r.ld[1]);
      end
      OP_ROLLBACK: begin
        for (p = r.sq_ptr; p != sq_tail; p = p + ptr_t'(1)) begin
          sq_state[idx_t'(p)] = EMPTY;
        end
        for (p = r.lq_ptr; p != lq_tail; p = p + ptr_t'(1)) begin
          lq_state[idx_t'(p)] = EMPTY;
        end
        sq_tail = r.sq_ptr;
        lq_tail = r.lq_ptr;
      end
      default: begin
      end
    endcase
  endtask

  initial begin
    cycle_count = 0;
    @(posedge clock);
    while (cycle_count < stim.size() * 4 + 100) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the stimulus table did not complete", cycle_count);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    drive_idle();
    reset <= 1'b1;
    build_table();
    sq_head = '0;
    sq_tail = '0;
    lq_head = '0;
    lq_tail = '0;
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      sq_state[i] = EMPTY;
      lq_state[i] = EMPTY;
    end
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_dispatch(1'b1, '0, '0);
    check_load_resp(1'b0, 1'b0, '0, '0);
    check_violation(1'b0, '0);
    check_mem_write('0, '0, '0);
    // Registered responses of each row are checked one cycle later
    foreach (stim[i]) begin
      @(posedge clock);
      drive_row(stim[i]);
      @(negedge clock);
      update_model(stim[i]);
      @(posedge clock);
      drive_idle();
      @(negedge clock);
      check_load_resp(exp_done, exp_hit, exp_fwd, exp_done_idx);
      check_violation(exp_viol, exp_viol_idx);
      check_mem_write(exp_en, exp_addr, exp_wdata);
    end
    $display("Errors: dispatch %0d, load response %0d, violation %0d, memory write %0d",
             err_dispatch, err_load, err_viol, err_mem);
    if (err_dispatch + err_load + err_viol + err_mem == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
